// File: hw/dtePkg.sv
package dtePkg;

  localparam int wordW      = 36;              // Machine word
  localparam int halfW      = 18;              // Reply half
  localparam int tickW      = 64;              // Tick counter and due times
  localparam int memAw      = 12;
  localparam int memDepth   = 1 << memAw;      // 4096 words
  localparam int queueDepth = 4;               // Request entries
  localparam int qPtrW      = $clog2(queueDepth);
  localparam int dsW        = 7;               // E-bus diagnostic function select

  // Microcode version fields packed into the left half of the processor ID
  localparam int ucodeMajorW = 6;
  localparam int ucodeMinorW = 3;
  localparam int ucodeEditW  = 9;

  typedef enum logic [2:0] {
    dteMisc            = 3'd0,
    dteWrite           = 3'd1,
    dteDiagFunc        = 3'd2,
    dteRead            = 3'd3,
    dteReleaseEbusData = 3'd4
  } tReqType;

  // Same field carries an E-bus function select for the E-bus classes
  typedef enum logic [dsW-1:0] {
    clrCrowbar   = 7'o01,
    getAprId     = 7'o02,
    readMemory   = 7'o03,
    writeMemory  = 7'o04,
    getDiagWord1 = 7'o05
  } tDiagFunc;

  typedef struct packed {
    tReqType               reqType;
    tDiagFunc              diagFunc;
    logic [tickW-1:0]      reqTime;            // Earliest tick to run
    logic [wordW-1:0]      data1;              // Address or E-bus data
    logic [wordW-1:0]      data2;              // Memory write data
  } tDteReq;

endpackage

// File: hw/dteIfc.sv
`timescale 1ns/1ns

interface ebusDiagIf import dtePkg::*; ();
  logic [dsW-1:0]   ds;                        // Function select to load
  logic             diagStrobe;                // Load ds and raise strobe
  logic             driving;                   // Load dataOut and start driving
  logic [wordW-1:0] dataOut;
  logic             releaseData;               // Drop driver, data and strobe
  logic [wordW-1:0] dataIn;                    // Sampled bus data

  modport ctl (
    output ds, diagStrobe, driving, dataOut, releaseData,
    input  dataIn
  );

  modport bus (
    input  ds, diagStrobe, driving, dataOut, releaseData,
    output dataIn
  );
endinterface

interface dteMemIf import dtePkg::*; ();
  logic             en;
  logic             we;
  logic [memAw-1:0] addr;
  logic [wordW-1:0] wdata;
  logic [wordW-1:0] rdata;                     // Valid the cycle after en

  modport ctl (
    output en, we, addr, wdata,
    input  rdata
  );

  modport mem (
    input  en, we, addr, wdata,
    output rdata
  );
endinterface

// File: hw/dteReqQueue.sv
`timescale 1ns/1ns

module dteReqQueue import dtePkg::*; (
  input  logic   clk,
  input  logic   arstN,
  input  logic   push,
  input  tDteReq pushItem,
  input  logic   pop,
  output tDteReq head,
  output logic   empty,
  output logic   full
);

  tDteReq           entries [queueDepth];
  logic [qPtrW-1:0] rdPtr;
  logic [qPtrW-1:0] wrPtr;
  logic [qPtrW:0]   count;                     // One extra bit to tell full from empty

  function automatic logic [qPtrW-1:0] nextPtr(input logic [qPtrW-1:0] ptr);
    logic [qPtrW-1:0] lastPtr;
    lastPtr = qPtrW'(queueDepth - 1);
    nextPtr = (ptr == lastPtr) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wrPtr] <= pushItem;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;             // Both or neither leave it unchanged
      endcase
    end
  end

  assign head  = entries[rdPtr];
  assign empty = (count == '0);
  assign full  = (count == (qPtrW + 1)'(queueDepth));

  // Host must watch reqFull, and the control only pops a present head
  assert property (@(posedge clk) disable iff (!arstN) !(push && full))
    else $error("request pushed while queue full");

  assert property (@(posedge clk) disable iff (!arstN) !(pop && empty))
    else $error("request popped while queue empty");

endmodule

// File: hw/dteCtl.sv
`timescale 1ns/1ns

module dteCtl import dtePkg::*; (
  input  logic                   clk,
  input  logic                   arstN,
  input  tDteReq                 head,
  input  logic                   empty,
  output logic                   pop,
  input  logic [ucodeMajorW-1:0] ucodeMajor,
  input  logic [ucodeMinorW-1:0] ucodeMinor,
  input  logic [ucodeEditW-1:0]  ucodeEdit,
  input  logic [halfW-1:0]       hwOptions,
  input  logic                   conRun,
  input  logic                   ebxHalted,
  output logic                   crowbar,
  output logic                   replyStrobe,
  output logic [tickW-1:0]       replyTime,
  output logic [halfW-1:0]       replyLh,
  output logic [halfW-1:0]       replyRh,
  ebusDiagIf.ctl                 ebus,
  dteMemIf.ctl                   mem
);

  typedef enum logic [1:0] {
    Idle,
    Exec,
    Reply
  } tState;

  tState            state;
  logic [tickW-1:0] tick;                      // Free running since reset
  tDteReq           req;                       // Request being carried out
  logic             due;
  logic             exec;
  logic             isMisc;
  logic             isMemOp;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      tick <= '0;
    end else begin
      tick <= tick + 1'b1;
    end
  end

  assign due  = !empty && (tick >= head.reqTime);
  assign pop  = (state == Idle) && due;
  assign exec = (state == Exec);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= Idle;
    end else begin
      case (state)
        Idle:    state <= due ? Exec : Idle;
        Exec:    state <= Reply;
        default: state <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      req <= head;
    end
  end

  assign isMisc  = (req.reqType == dteMisc);
  assign isMemOp = isMisc && (req.diagFunc == readMemory || req.diagFunc == writeMemory);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      crowbar <= 1'b1;                         // Held until the host clears it
    end else if (exec && isMisc && req.diagFunc == clrCrowbar) begin
      crowbar <= 1'b0;
    end
  end

  // Memory access goes out in Exec so read data lands in Reply
  assign mem.en    = exec && isMemOp;
  assign mem.we    = exec && isMisc && (req.diagFunc == writeMemory);
  assign mem.addr  = req.data1[memAw-1:0];
  assign mem.wdata = req.data2;

  // E-bus load commands are single-cycle pulses in Exec
  assign ebus.ds          = req.diagFunc;
  assign ebus.diagStrobe  = exec && (req.reqType == dteWrite || req.reqType == dteDiagFunc);
  assign ebus.driving     = exec && (req.reqType == dteWrite);
  assign ebus.dataOut     = req.data1;
  assign ebus.releaseData = exec && (req.reqType == dteReleaseEbusData);

  assign replyStrobe = (state == Reply);
  assign replyTime   = tick;

  always_comb begin
    replyLh = '0;
    replyRh = '0;
    if (isMisc) begin
      case (req.diagFunc)
        getAprId: begin
          replyLh = {ucodeMajor, ucodeMinor, ucodeEdit};
          replyRh = hwOptions;
        end
        readMemory: begin
          replyLh = mem.rdata[wordW-1:halfW];
          replyRh = mem.rdata[halfW-1:0];
        end
        getDiagWord1: replyRh = {{(halfW - 2){1'b0}}, conRun, ebxHalted};
        default: ;                             // Crowbar, write and unknown codes reply zero
      endcase
    end else begin
      replyLh = ebus.dataIn[wordW-1:halfW];    // All E-bus classes return bus data
      replyRh = ebus.dataIn[halfW-1:0];
    end
  end

  assert property (@(posedge clk) disable iff (!arstN) replyStrobe |=> !replyStrobe)
    else $error("replyStrobe held for two cycles");

endmodule

// File: hw/ebusDiag.sv
`timescale 1ns/1ns

module ebusDiag import dtePkg::*; (
  input  logic             clk,
  input  logic             arstN,
  ebusDiagIf.bus           ctl,
  output logic [dsW-1:0]   ebusDs,
  output logic             ebusDiagStrobe,
  output logic             ebusDriving,
  output logic [wordW-1:0] ebusDataOut,
  input  logic [wordW-1:0] ebusDataIn
);

  // Outputs hold between commands from the control module
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ebusDs         <= '0;
      ebusDiagStrobe <= 1'b0;
      ebusDriving    <= 1'b0;
      ebusDataOut    <= '0;
    end else if (ctl.releaseData) begin
      ebusDiagStrobe <= 1'b0;
      ebusDriving    <= 1'b0;
      ebusDataOut    <= '0;                    // Bus lines float back to zero
    end else begin
      if (ctl.diagStrobe) begin
        ebusDs         <= ctl.ds;
        ebusDiagStrobe <= 1'b1;
      end
      if (ctl.driving) begin
        ebusDriving <= 1'b1;
        ebusDataOut <= ctl.dataOut;
      end
    end
  end

  assign ctl.dataIn = ebusDataIn;              // Sampled by the control in Reply

  // Data only leaves the front end while the driver is enabled
  assert property (@(posedge clk) disable iff (!arstN) !ebusDriving |-> ebusDataOut == '0)
    else $error("ebusDataOut nonzero while not driving");

endmodule

// File: hw/dteMemory.sv
`timescale 1ns/1ns

module dteMemory import dtePkg::*; (
  input logic  clk,
  dteMemIf.mem mem
);

  logic [wordW-1:0] ram [memDepth];            // Contents undefined at power up

  // Registered read returns the old word on a same-cycle write
  always_ff @(posedge clk) begin
    if (mem.en) begin
      if (mem.we) begin
        ram[mem.addr] <= mem.wdata;
      end
      mem.rdata <= ram[mem.addr];
    end
  end

endmodule

// File: hw/dteTop.sv
`timescale 1ns/1ns

module dteTop import dtePkg::*; (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   reqStrobe,
  input  tReqType                reqType,
  input  tDiagFunc               diagFunc,
  input  logic [tickW-1:0]       reqTime,
  input  logic [wordW-1:0]       reqData1,
  input  logic [wordW-1:0]       reqData2,
  output logic                   reqFull,
  output logic                   replyStrobe,
  output logic [tickW-1:0]       replyTime,
  output logic [halfW-1:0]       replyLh,
  output logic [halfW-1:0]       replyRh,
  output logic                   crowbar,
  input  logic [ucodeMajorW-1:0] ucodeMajor,
  input  logic [ucodeMinorW-1:0] ucodeMinor,
  input  logic [ucodeEditW-1:0]  ucodeEdit,
  input  logic [halfW-1:0]       hwOptions,
  input  logic                   conRun,
  input  logic                   ebxHalted,
  output logic [dsW-1:0]         ebusDs,
  output logic                   ebusDiagStrobe,
  output logic                   ebusDriving,
  output logic [wordW-1:0]       ebusDataOut,
  input  logic [wordW-1:0]       ebusDataIn
);

  tDteReq pushItem;
  tDteReq head;
  logic   empty;
  logic   pop;

  ebusDiagIf ebusIf ();
  dteMemIf   memIf ();

  always_comb begin
    pushItem.reqType  = reqType;
    pushItem.diagFunc = diagFunc;
    pushItem.reqTime  = reqTime;
    pushItem.data1    = reqData1;
    pushItem.data2    = reqData2;
  end

  dteReqQueue reqQueue0 (
    .clk      (clk),
    .arstN    (arstN),
    .push     (reqStrobe),
    .pushItem (pushItem),
    .pop      (pop),
    .head     (head),
    .empty    (empty),
    .full     (reqFull)
  );

  dteCtl ctl0 (
    .clk         (clk),
    .arstN       (arstN),
    .head        (head),
    .empty       (empty),
    .pop         (pop),
    .ucodeMajor  (ucodeMajor),
    .ucodeMinor  (ucodeMinor),
    .ucodeEdit   (ucodeEdit),
    .hwOptions   (hwOptions),
    .conRun      (conRun),
    .ebxHalted   (ebxHalted),
    .crowbar     (crowbar),
    .replyStrobe (replyStrobe),
    .replyTime   (replyTime),
    .replyLh     (replyLh),
    .replyRh     (replyRh),
    .ebus        (ebusIf.ctl),
    .mem         (memIf.ctl)
  );

  ebusDiag ebusDiag0 (
    .clk            (clk),
    .arstN          (arstN),
    .ctl            (ebusIf.bus),
    .ebusDs         (ebusDs),
    .ebusDiagStrobe (ebusDiagStrobe),
    .ebusDriving    (ebusDriving),
    .ebusDataOut    (ebusDataOut),
    .ebusDataIn     (ebusDataIn)
  );

  dteMemory memory0 (
    .clk (clk),
    .mem (memIf.mem)
  );

endmodule

// File: bench/dteTb.sv
`timescale 1ns/1ns

module dteTb import dtePkg::*; ();

  typedef enum logic [1:0] {
    busNone,
    busDrive,                                  // Write loaded select, strobe and data
    busRelease,                                // Driver, strobe and data dropped
    busCrowbar                                 // Crowbar cleared by this request
  } tBusCheck;

  logic                   clk;
  logic                   arstN;
  logic                   reqStrobe;
  tReqType                reqType;
  tDiagFunc               diagFunc;
  logic [tickW-1:0]       reqTime;
  logic [wordW-1:0]       reqData1;
  logic [wordW-1:0]       reqData2;
  logic                   reqFull;
  logic                   replyStrobe;
  logic [tickW-1:0]       replyTime;
  logic [halfW-1:0]       replyLh;
  logic [halfW-1:0]       replyRh;
  logic                   crowbar;
  logic [ucodeMajorW-1:0] ucodeMajor;
  logic [ucodeMinorW-1:0] ucodeMinor;
  logic [ucodeEditW-1:0]  ucodeEdit;
  logic [halfW-1:0]       hwOptions;
  logic                   conRun;
  logic                   ebxHalted;
  logic [dsW-1:0]         ebusDs;
  logic                   ebusDiagStrobe;
  logic                   ebusDriving;
  logic [wordW-1:0]       ebusDataOut;
  logic [wordW-1:0]       ebusDataIn;

  // Expected replies in request order
  string            expName [64];
  logic [halfW-1:0] expLh [64];
  logic [halfW-1:0] expRh [64];
  logic [tickW-1:0] expTime [64];
  logic             expExact [64];           // Exact reply tick, else earliest tick
  tBusCheck         expBus [64];
  logic [dsW-1:0]   expDs [64];
  logic [wordW-1:0] expData [64];
  int               wrIdx;
  int               rdIdx;

  logic [halfW-1:0] curLh;
  logic [halfW-1:0] curRh;
  logic [tickW-1:0] curTime;
  logic             curExact;
  tBusCheck         curBus;
  logic [dsW-1:0]   curDs;
  logic [wordW-1:0] curData;

  logic [wordW-1:0] memModel [logic [memAw-1:0]];
  logic [memAw-1:0] addrList [8];
  logic [wordW-1:0] busWord;                   // Word the E-bus responder returns
  logic [tickW-1:0] tbTick;                    // Reference tick, 0 after reset
  logic [31:0]      lfsrState = 32'h819c;
  logic             checkIdle;
  logic             expectFull;

  dteTop dut0 (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      tbTick <= '0;
      rdIdx  <= 0;
    end else begin
      tbTick <= tbTick + 1'b1;
      if (replyStrobe) begin
        rdIdx <= rdIdx + 1;                    // Next expected reply
      end
    end
  end

  assign curLh    = expLh[rdIdx];
  assign curRh    = expRh[rdIdx];
  assign curTime  = expTime[rdIdx];
  assign curExact = expExact[rdIdx];
  assign curBus   = expBus[rdIdx];
  assign curDs    = expDs[rdIdx];
  assign curData  = expData[rdIdx];

  function automatic logic [63:0] lfsrBits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'hA300_0000) : (lfsrState >> 1);
      v = {v[62:0], lfsrState[0]};
    end
    return v;
  endfunction

  task automatic flagMismatch(input string name, input string what,
                              input logic [63:0] expV, input logic [63:0] actV);
    $display("mismatch %s %s expected %0h actual %0h", name, what, expV, actV);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic abortRun(input string text);
    $display("%s", text);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  // Called on a falling edge, returns on the next one
  task automatic sendRequest(input string name, input tReqType kind, input logic [dsW-1:0] func,
                             input logic [tickW-1:0] due, input logic [wordW-1:0] d1,
                             input logic [wordW-1:0] d2, input logic [wordW-1:0] expWord,
                             input logic exact, input tBusCheck busCheck);
    expName[wrIdx]  = name;
    expLh[wrIdx]    = expWord[wordW-1:halfW];
    expRh[wrIdx]    = expWord[halfW-1:0];
    expTime[wrIdx]  = exact ? tbTick + 3 : due;  // Queued next edge, due one cycle later
    expExact[wrIdx] = exact;
    expBus[wrIdx]   = busCheck;
    expDs[wrIdx]    = func;
    expData[wrIdx]  = d1;
    wrIdx           = wrIdx + 1;
    reqType   = kind;
    diagFunc  = tDiagFunc'(func);
    reqTime   = due;
    reqData1  = d1;
    reqData2  = d2;
    reqStrobe = 1'b1;
    @(negedge clk);
    reqStrobe = 1'b0;
  endtask

  task automatic awaitReply(input string name, input int limit);
    int n;
    n = 0;
    while (replyStrobe !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > limit) begin
        abortRun($sformatf("timeout waiting for the reply of %s", name));
      end
    end
    @(negedge clk);                            // Control is idle again
  endtask

  assert property (@(posedge clk) disable iff (!arstN) replyStrobe |-> replyLh == curLh)
    else flagMismatch(expName[$sampled(rdIdx)], "replyLh", $sampled(curLh), $sampled(replyLh));

  assert property (@(posedge clk) disable iff (!arstN) replyStrobe |-> replyRh == curRh)
    else flagMismatch(expName[$sampled(rdIdx)], "replyRh", $sampled(curRh), $sampled(replyRh));

  assert property (@(posedge clk) disable iff (!arstN)
                   replyStrobe |-> (curExact ? replyTime == curTime : replyTime >= curTime))
    else flagMismatch(expName[$sampled(rdIdx)], "replyTime", $sampled(curTime),
                      $sampled(replyTime));

  assert property (@(posedge clk) disable iff (!arstN) replyStrobe |-> rdIdx < wrIdx)
    else abortRun("reply seen with no request outstanding");

  assert property (@(posedge clk) disable iff (!arstN)
                   replyStrobe && curBus == busDrive |-> ebusDs == curDs)
    else flagMismatch(expName[$sampled(rdIdx)], "ebusDs", $sampled(curDs), $sampled(ebusDs));

  assert property (@(posedge clk) disable iff (!arstN)
                   replyStrobe && curBus == busDrive |-> ebusDataOut == curData)
    else flagMismatch(expName[$sampled(rdIdx)], "ebusDataOut", $sampled(curData),
                      $sampled(ebusDataOut));

  assert property (@(posedge clk) disable iff (!arstN)
                   replyStrobe && curBus == busDrive |-> ebusDiagStrobe && ebusDriving)
    else abortRun("E-bus strobe or driver not raised by a diagnostic write");

  assert property (@(posedge clk) disable iff (!arstN) replyStrobe && curBus == busRelease
                   |-> !ebusDriving && !ebusDiagStrobe && ebusDataOut == '0)
    else abortRun("E-bus driver, strobe or data still active after release");

  assert property (@(posedge clk) disable iff (!arstN)
                   replyStrobe && curBus == busCrowbar |-> !crowbar)
    else abortRun("crowbar still set after clrCrowbar");

  assert property (@(posedge clk) disable iff (!arstN) checkIdle |-> crowbar && !replyStrobe
                   && !ebusDiagStrobe && !ebusDriving && ebusDs == '0 && ebusDataOut == '0)
    else abortRun("outputs not in their reset state after reset");

  assert property (@(posedge clk) disable iff (!arstN) expectFull |-> reqFull)
    else abortRun("reqFull low with four requests queued");

  initial begin
    logic [memAw-1:0] addr;
    logic [wordW-1:0] d1;
    logic [wordW-1:0] d2;
    logic [dsW-1:0]   code;
    logic [tickW-1:0] due;
    arstN      = 1'b0;
    reqStrobe  = 1'b0;
    reqType    = dteMisc;
    diagFunc   = clrCrowbar;
    reqTime    = '0;
    reqData1   = '0;
    reqData2   = '0;
    conRun     = 1'b0;
    ebxHalted  = 1'b0;
    checkIdle  = 1'b0;
    expectFull = 1'b0;
    wrIdx      = 0;
    ucodeMajor = lfsrBits(ucodeMajorW);
    ucodeMinor = lfsrBits(ucodeMinorW);
    ucodeEdit  = lfsrBits(ucodeEditW);
    hwOptions  = lfsrBits(halfW);
    busWord    = lfsrBits(wordW);
    ebusDataIn = busWord;
    repeat (5) @(negedge clk);
    arstN     = 1'b1;
    checkIdle = 1'b1;
    @(negedge clk);
    checkIdle = 1'b0;

    sendRequest("clrCrowbar", dteMisc, clrCrowbar, tbTick, '0, '0, '0, 1'b1, busCrowbar);
    awaitReply("clrCrowbar", 20);

    sendRequest("getAprId", dteMisc, getAprId, tbTick, '0, '0,
                {ucodeMajor, ucodeMinor, ucodeEdit, hwOptions}, 1'b1, busNone);
    awaitReply("getAprId", 20);
    for (int i = 0; i < 4; i++) begin
      {conRun, ebxHalted} = 2'(i);
      sendRequest("getDiagWord1", dteMisc, getDiagWord1, tbTick, '0, '0, 36'(i), 1'b1, busNone);
      awaitReply("getDiagWord1", 20);
    end

    for (int i = 0; i < 8; i++) begin
      addr          = lfsrBits(memAw);
      d1            = lfsrBits(wordW);
      d1[memAw-1:0] = addr;                    // High bits are ignored
      d2            = lfsrBits(wordW);
      memModel[addr] = d2;
      addrList[i]    = addr;
      sendRequest("writeMemory", dteMisc, writeMemory, tbTick, d1, d2, '0, 1'b1, busNone);
      awaitReply("writeMemory", 20);
    end
    for (int i = 0; i < 8; i++) begin
      d1            = lfsrBits(wordW);
      d1[memAw-1:0] = addrList[i];
      sendRequest("readMemory", dteMisc, readMemory, tbTick, d1, '0, memModel[addrList[i]],
                  1'b1, busNone);
      awaitReply("readMemory", 20);
    end

    code = lfsrBits(dsW);
    d1   = lfsrBits(wordW);
    sendRequest("ebusWrite", dteWrite, code, tbTick, d1, '0, busWord, 1'b1, busDrive);
    awaitReply("ebusWrite", 20);
    code = lfsrBits(dsW);
    sendRequest("ebusDiagFunc", dteDiagFunc, code, tbTick, '0, '0, busWord, 1'b1, busNone);
    awaitReply("ebusDiagFunc", 20);
    busWord    = lfsrBits(wordW);
    ebusDataIn = busWord;
    sendRequest("ebusRead", dteRead, '0, tbTick, '0, '0, busWord, 1'b1, busNone);
    awaitReply("ebusRead", 20);
    sendRequest("ebusRelease", dteReleaseEbusData, '0, tbTick, '0, '0, busWord, 1'b1,
                busRelease);
    awaitReply("ebusRelease", 20);

    sendRequest("dueNow", dteMisc, getAprId, '0, '0, '0,
                {ucodeMajor, ucodeMinor, ucodeEdit, hwOptions}, 1'b1, busNone);
    awaitReply("dueNow", 20);
    due = tbTick + 25;
    sendRequest("futureDue", dteMisc, getAprId, due, '0, '0,
                {ucodeMajor, ucodeMinor, ucodeEdit, hwOptions}, 1'b0, busNone);
    awaitReply("futureDue", 60);

    due = tbTick + 10;                         // Holds all four until the queue is full
    for (int i = 0; i < 4; i++) begin
      d1            = lfsrBits(wordW);
      d1[memAw-1:0] = addrList[i];
      sendRequest($sformatf("queued%0d", i), dteMisc, readMemory, due, d1, '0,
                  memModel[addrList[i]], 1'b0, busNone);
    end
    expectFull = 1'b1;
    @(negedge clk);
    expectFull = 1'b0;
    for (int i = 0; i < 4; i++) begin
      awaitReply($sformatf("queued%0d", i), 40);
    end

    @(negedge clk);
    if (rdIdx != wrIdx) begin
      abortRun("fewer replies than requests");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: src.f
hw/dtePkg.sv
hw/dteIfc.sv
hw/dteReqQueue.sv
hw/dteCtl.sv
hw/ebusDiag.sv
hw/dteMemory.sv
hw/dteTop.sv
bench/dteTb.sv

// File: Bender.yml
package:
  name: dte

sources:
  - hw/dtePkg.sv
  - hw/dteIfc.sv
  - hw/dteReqQueue.sv
  - hw/dteCtl.sv
  - hw/ebusDiag.sv
  - hw/dteMemory.sv
  - hw/dteTop.sv
  - target: simulation
    files:
      - bench/dteTb.sv
